// ==== logic/issue_pkg.sv ====
package issue_pkg;

    localparam int xlen  = 32;
    localparam int reg_w = 5;
    localparam int tag_w = 4; // Tag 0 means the value is ready

    // RV32I major opcodes handled by this stage
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;

    // Instruction classes
    localparam logic [2:0] cls_alu     = 3'd0;
    localparam logic [2:0] cls_load    = 3'd1;
    localparam logic [2:0] cls_store   = 3'd2;
    localparam logic [2:0] cls_lui     = 3'd3;
    localparam logic [2:0] cls_illegal = 3'd4;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]      imm12;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]       imm_hi;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [4:0]       imm_lo;
        logic [6:0]       opcode;
    } s_view_t;

    typedef struct packed {
        logic [19:0]      imm20;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } u_view_t;

    // Same 32-bit word, read through the format that the opcode selects
    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        u_view_t u;
    } instr_t;

    typedef struct packed {
        instr_t          instr;
        logic [xlen-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic [2:0]       cls;
        logic [3:0]       alu_op;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rs1;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  imm;
        logic             uses_rs2;
        logic             uses_pc;  // AUIPC takes pc as first operand
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]  value;
        logic [tag_w-1:0] tag;
    } operand_t;

    typedef struct packed {
        logic [3:0]       op;
        logic [xlen-1:0]  vj;
        logic [xlen-1:0]  vk;
        logic [tag_w-1:0] qj;
        logic [tag_w-1:0] qk;
        logic [tag_w-1:0] dest;
    } alu_issue_t;

    typedef struct packed {
        logic [2:0]       op;
        logic [xlen-1:0]  vj;
        logic [tag_w-1:0] qj;
        logic [11:0]      offset;
        logic [tag_w-1:0] dest;
    } load_issue_t;

    typedef struct packed {
        logic [2:0]       op;
        logic [xlen-1:0]  vj;
        logic [xlen-1:0]  vk;
        logic [tag_w-1:0] qj;
        logic [tag_w-1:0] qk;
        logic [11:0]      offset;
        logic [tag_w-1:0] dest;
    } store_issue_t;

endpackage

// ==== logic/instr_decoder.sv ====
module instr_decoder import issue_pkg::*; (
    input  instr_t   instr,
    output decoded_t decoded
);

    logic            is_shift;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] shamt;

    assign is_shift = (instr.i.funct3 == 3'b001) || (instr.i.funct3 == 3'b101);

    // Immediate formats, one per union view
    assign imm_i = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_s = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_u = {instr.u.imm20, 12'b0};
    assign shamt = {{(xlen-reg_w){1'b0}}, instr.r.rs2}; // Shamt sits in the rs2 slot

    always_comb begin
        decoded = '0;
        decoded.funct3 = instr.r.funct3;

        case (instr.r.opcode)
            op_alu_reg: begin
                decoded.cls      = cls_alu;
                decoded.alu_op   = {instr.r.funct7[5], instr.r.funct3};
                decoded.rs1      = instr.r.rs1;
                decoded.rs2      = instr.r.rs2;
                decoded.rd       = instr.r.rd;
                decoded.uses_rs2 = 1'b1;
            end
            op_alu_imm: begin
                decoded.cls = cls_alu;
                decoded.rs1 = instr.i.rs1;
                decoded.rd  = instr.i.rd;
                if (is_shift) begin
                    // Bit 30 picks SRAI over SRLI
                    decoded.alu_op = {instr.r.funct7[5], instr.i.funct3};
                    decoded.imm    = shamt;
                end else begin
                    decoded.alu_op = {1'b0, instr.i.funct3};
                    decoded.imm    = imm_i;
                end
            end
            op_load: begin
                decoded.cls = cls_load;
                decoded.rs1 = instr.i.rs1;
                decoded.rd  = instr.i.rd;
                decoded.imm = imm_i;
            end
            op_store: begin
                decoded.cls      = cls_store;
                decoded.rs1      = instr.s.rs1;
                decoded.rs2      = instr.s.rs2;
                decoded.imm      = imm_s; // rd stays x0
                decoded.uses_rs2 = 1'b1;
            end
            op_lui: begin
                decoded.cls = cls_lui;
                decoded.rd  = instr.u.rd;
                decoded.imm = imm_u;
            end
            op_auipc: begin
                decoded.cls     = cls_alu; // Adds pc and U immediate with alu_op 0
                decoded.rd      = instr.u.rd;
                decoded.imm     = imm_u;
                decoded.uses_pc = 1'b1;
            end
            default: begin
                decoded.cls = cls_illegal;
            end
        endcase
    end

endmodule

// ==== logic/operand_table.sv ====
module operand_table import issue_pkg::*; (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             fetch_valid,
    input  decoded_t         decoded,
    input  logic [tag_w-1:0] alloc_tag,
    input  logic             cdb_valid,
    input  cdb_t             cdb,
    output operand_t         src1,
    output operand_t         src2
);

    // x0 has no entry
    logic [xlen-1:0]  val_q [1:31];
    logic [tag_w-1:0] tag_q [1:31];

    logic writes_tag;
    logic writes_lui;

    function automatic operand_t lookup(input logic [reg_w-1:0] idx);
        operand_t res;
        res = '0;
        if (idx != '0) begin
            if (tag_q[idx] == '0) begin
                res.value = val_q[idx];
            end else if (cdb_valid && (cdb.tag == tag_q[idx])) begin
                res.value = cdb.value; // Result arriving this cycle
            end else begin
                res.tag = tag_q[idx];
            end
        end
        return res;
    endfunction

    always_comb begin
        src1 = lookup(decoded.rs1);
        src2 = lookup(decoded.rs2);
    end

    assign writes_tag = fetch_valid && (decoded.rd != '0) &&
                        ((decoded.cls == cls_alu) || (decoded.cls == cls_load));
    assign writes_lui = fetch_valid && (decoded.rd != '0) && (decoded.cls == cls_lui);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                val_q[i] <= '0;
                tag_q[i] <= '0;
            end
        end else begin
            // Results retire waiting entries
            for (int i = 1; i < 32; i++) begin
                if (cdb_valid && (tag_q[i] != '0) && (tag_q[i] == cdb.tag)) begin
                    val_q[i] <= cdb.value;
                    tag_q[i] <= '0;
                end
            end

            // Issue comes last so it overrides a result on the same entry
            if (writes_tag) begin
                tag_q[decoded.rd] <= alloc_tag;
            end else if (writes_lui) begin
                val_q[decoded.rd] <= decoded.imm;
                tag_q[decoded.rd] <= '0;
            end
        end
    end

    // A renamed destination must be left waiting on a live tag
    a_pending_tag_live: assert property (
        @(posedge clk_in) disable iff (reset)
        writes_tag |=> (tag_q[$past(decoded.rd)] != '0)
    );

endmodule

// ==== logic/dispatch_unit.sv ====
module dispatch_unit import issue_pkg::*; (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             fetch_valid,
    input  logic [xlen-1:0]  pc,
    input  decoded_t         decoded,
    input  operand_t         src1,
    input  operand_t         src2,
    output logic [tag_w-1:0] alloc_tag,
    output logic             alu_valid,
    output logic             load_valid,
    output logic             store_valid,
    output logic             illegal,
    output alu_issue_t       alu_issue,
    output load_issue_t      load_issue,
    output store_issue_t     store_issue
);

    logic [tag_w-1:0] tag_q;
    logic             uses_tag;
    alu_issue_t       alu_next;
    load_issue_t      load_next;
    store_issue_t     store_next;

    assign alloc_tag = tag_q;

    // Only renamed destinations consume a tag
    assign uses_tag = fetch_valid && (decoded.rd != '0) &&
                      ((decoded.cls == cls_alu) || (decoded.cls == cls_load));

    always_comb begin
        alu_next.op   = decoded.alu_op;
        alu_next.vj   = decoded.uses_pc ? pc : src1.value;
        alu_next.qj   = decoded.uses_pc ? '0 : src1.tag;
        alu_next.vk   = decoded.uses_rs2 ? src2.value : decoded.imm;
        alu_next.qk   = decoded.uses_rs2 ? src2.tag : '0;
        alu_next.dest = tag_q;

        load_next.op     = decoded.funct3;
        load_next.vj     = src1.value;
        load_next.qj     = src1.tag;
        load_next.offset = decoded.imm[11:0];
        load_next.dest   = tag_q;

        store_next.op     = decoded.funct3;
        store_next.vj     = src1.value; // Base address
        store_next.vk     = src2.value; // Data to store
        store_next.qj     = src1.tag;
        store_next.qk     = src2.tag;
        store_next.offset = decoded.imm[11:0];
        store_next.dest   = tag_q;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            tag_q       <= tag_w'(1);
            alu_valid   <= 1'b0;
            load_valid  <= 1'b0;
            store_valid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            if (uses_tag) begin
                tag_q <= (tag_q == {tag_w{1'b1}}) ? tag_w'(1) : tag_q + 1'b1; // Skip 0
            end
            alu_valid   <= fetch_valid && (decoded.cls == cls_alu);
            load_valid  <= fetch_valid && (decoded.cls == cls_load);
            store_valid <= fetch_valid && (decoded.cls == cls_store);
            illegal     <= fetch_valid && (decoded.cls == cls_illegal);
        end
    end

    // Payloads only change with their own strobe
    always_ff @(posedge clk_in) begin
        if (fetch_valid && (decoded.cls == cls_alu)) alu_issue <= alu_next;
        if (fetch_valid && (decoded.cls == cls_load)) load_issue <= load_next;
        if (fetch_valid && (decoded.cls == cls_store)) store_issue <= store_next;
    end

    a_one_strobe: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot0({alu_valid, load_valid, store_valid, illegal})
    );

    // Any station issue carries a live tag
    a_dest_live: assert property (
        @(posedge clk_in) disable iff (reset)
        (!alu_valid || (alu_issue.dest != '0)) &&
        (!load_valid || (load_issue.dest != '0)) &&
        (!store_valid || (store_issue.dest != '0))
    );

endmodule

// ==== logic/issue_top.sv ====
module issue_top import issue_pkg::*; (
    input  logic         clk_in,
    input  logic         reset,
    input  logic         fetch_valid,
    input  fetch_t       fetch,
    input  logic         cdb_valid,
    input  cdb_t         cdb,
    output logic         alu_valid,
    output alu_issue_t   alu_issue,
    output logic         load_valid,
    output load_issue_t  load_issue,
    output logic         store_valid,
    output store_issue_t store_issue,
    output logic         illegal
);

    decoded_t         decoded;
    operand_t         src1;
    operand_t         src2;
    logic [tag_w-1:0] alloc_tag;

    instr_decoder u_decoder (
        .instr   (fetch.instr),
        .decoded (decoded)
    );

    operand_table u_table (
        .clk_in      (clk_in),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .decoded     (decoded),
        .alloc_tag   (alloc_tag),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .src1        (src1),
        .src2        (src2)
    );

    dispatch_unit u_dispatch (
        .clk_in      (clk_in),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .pc          (fetch.pc),
        .decoded     (decoded),
        .src1        (src1),
        .src2        (src2),
        .alloc_tag   (alloc_tag),
        .alu_valid   (alu_valid),
        .load_valid  (load_valid),
        .store_valid (store_valid),
        .illegal     (illegal),
        .alu_issue   (alu_issue),
        .load_issue  (load_issue),
        .store_issue (store_issue)
    );

endmodule

// ==== tb/issue_vectors.svh ====
// One row per cycle with name, fetch_valid, instr, pc, cdb_valid, cdb tag, cdb value,
// expected strobes {alu, load, store, illegal}, op, vj, vk, qj, qk, offset, dest

task automatic build_table();
    add_row("idle_after_reset", 1'b0, 32'h0, 32'h0, 1'b0, 4'd0, 32'h0,
            4'b0000, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd0);
    add_row("add_x6_x1_x2", 1'b1, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd6, op_alu_reg),
            32'h100, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd1);
    add_row("lw_x5_8_x1", 1'b1, i_type(12'd8, 5'd1, 3'b010, 5'd5, op_load),
            32'h104, 1'b0, 4'd0, 32'h0,
            4'b0100, 4'h2, 32'h0, 32'h0, 4'd0, 4'd0, 12'h008, 4'd2);
    // Reads both pending results and rd x0 keeps the counter
    add_row("sub_x0_x5_x6", 1'b1, r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd0, op_alu_reg),
            32'h108, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h8, 32'h0, 32'h0, 4'd2, 4'd1, 12'h0, 4'd3);
    add_row("cdb_tag2", 1'b0, 32'h0, 32'h0, 1'b1, 4'd2, 32'h1234_5678,
            4'b0000, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd0);
    add_row("add_x7_x5_x0", 1'b1, r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd7, op_alu_reg),
            32'h10c, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h0, 32'h1234_5678, 32'h0, 4'd0, 4'd0, 12'h0, 4'd3);
    // Tag 1 for x6 arrives on the CDB in the same cycle
    add_row("or_x8_x6_x7_bypass", 1'b1, r_type(7'h00, 5'd7, 5'd6, 3'b110, 5'd8, op_alu_reg),
            32'h110, 1'b1, 4'd1, 32'hcafe_0001,
            4'b1000, 4'h6, 32'hcafe_0001, 32'h0, 4'd0, 4'd3, 12'h0, 4'd4);
    add_row("lui_x3", 1'b1, u_type(20'habcde, 5'd3, op_lui),
            32'h114, 1'b0, 4'd0, 32'h0,
            4'b0000, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd0);
    add_row("addi_x4_x3_5", 1'b1, i_type(12'd5, 5'd3, 3'b000, 5'd4, op_alu_imm),
            32'h118, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h0, 32'habcd_e000, 32'h5, 4'd0, 4'd0, 12'h0, 4'd5);
    add_row("srai_x9_x6_7", 1'b1, i_type(12'h407, 5'd6, 3'b101, 5'd9, op_alu_imm),
            32'h11c, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'hd, 32'hcafe_0001, 32'h7, 4'd0, 4'd0, 12'h0, 4'd6);
    add_row("addi_x10_x0_neg3", 1'b1, i_type(12'hffd, 5'd0, 3'b000, 5'd10, op_alu_imm),
            32'h120, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h0, 32'h0, 32'hffff_fffd, 4'd0, 4'd0, 12'h0, 4'd7);
    add_row("sw_x8_neg4_x5", 1'b1, s_type(12'hffc, 5'd8, 5'd5, 3'b010, op_store),
            32'h124, 1'b0, 4'd0, 32'h0,
            4'b0010, 4'h2, 32'h1234_5678, 32'h0, 4'd0, 4'd4, 12'hffc, 4'd8);
    add_row("xor_x11_x4_x0", 1'b1, r_type(7'h00, 5'd0, 5'd4, 3'b100, 5'd11, op_alu_reg),
            32'h128, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h4, 32'h0, 32'h0, 4'd5, 4'd0, 12'h0, 4'd8);
    add_row("auipc_x12", 1'b1, u_type(20'h00012, 5'd12, op_auipc),
            32'h400, 1'b0, 4'd0, 32'h0,
            4'b1000, 4'h0, 32'h400, 32'h0001_2000, 4'd0, 4'd0, 12'h0, 4'd9);
    add_row("jal_illegal", 1'b1, 32'h0080_006f, 32'h404, 1'b0, 4'd0, 32'h0,
            4'b0001, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd0);
    add_row("idle_end", 1'b0, 32'h0, 32'h0, 1'b0, 4'd0, 32'h0,
            4'b0000, 4'h0, 32'h0, 32'h0, 4'd0, 4'd0, 12'h0, 4'd0);
endtask

// ==== tb/issue_tb.sv ====
module issue_tb import issue_pkg::*; ();

    typedef struct packed {
        logic        fetch_valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        cdb_valid;
        logic [3:0]  cdb_tag;
        logic [31:0] cdb_value;
        logic [3:0]  strobes;  // {alu, load, store, illegal}
        logic [3:0]  op;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [3:0]  qj;
        logic [3:0]  qk;
        logic [11:0] offset;
        logic [3:0]  dest;
    } vec_t;

    logic         clk_in;
    logic         reset;
    logic         fetch_valid;
    fetch_t       fetch;
    logic         cdb_valid;
    cdb_t         cdb;
    logic         alu_valid;
    alu_issue_t   alu_issue;
    logic         load_valid;
    load_issue_t  load_issue;
    logic         store_valid;
    store_issue_t store_issue;
    logic         illegal;

    vec_t  rows [$];
    string names [$];
    int    cycle_count = 0;
    int    cycle_limit = 20;

    issue_top UUT (
        .clk_in      (clk_in),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .alu_valid   (alu_valid),
        .alu_issue   (alu_issue),
        .load_valid  (load_valid),
        .load_issue  (load_issue),
        .store_valid (store_valid),
        .store_issue (store_issue),
        .illegal     (illegal)
    );

    // RV32I instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op}; // Offset split around rs2/rs1
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic add_row(input string name, input logic fv, input logic [31:0] instr,
                           input logic [31:0] pc, input logic cv, input logic [3:0] ctag,
                           input logic [31:0] cval, input logic [3:0] strobes,
                           input logic [3:0] op, input logic [31:0] vj, input logic [31:0] vk,
                           input logic [3:0] qj, input logic [3:0] qk,
                           input logic [11:0] offset, input logic [3:0] dest);
        vec_t v;
        v = {fv, instr, pc, cv, ctag, cval, strobes, op, vj, vk, qj, qk, offset, dest};
        rows.push_back(v);
        names.push_back(name);
    endtask

    `include "issue_vectors.svh"

    task automatic check_field(input string name, input string field,
                               input logic [127:0] expected, input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s %s expected %0h, actual %0h", name, field, expected, actual);
            $display("Verification failed");
            $fatal(1, "Issue output mismatch");
        end
    endtask

    task automatic drive_row(input vec_t v);
        fetch_valid = v.fetch_valid;
        fetch.instr = v.instr;
        fetch.pc    = v.pc;
        cdb_valid   = v.cdb_valid;
        cdb.tag     = v.cdb_tag;
        cdb.value   = v.cdb_value;
    endtask

    task automatic check_row(input int k);
        vec_t         v;
        alu_issue_t   exp_alu;
        load_issue_t  exp_load;
        store_issue_t exp_store;
        v = rows[k];
        exp_alu   = {v.op, v.vj, v.vk, v.qj, v.qk, v.dest};
        exp_load  = {v.op[2:0], v.vj, v.qj, v.offset, v.dest};
        exp_store = {v.op[2:0], v.vj, v.vk, v.qj, v.qk, v.offset, v.dest};
        check_field(names[k], "strobes", 128'(v.strobes),
                    128'({alu_valid, load_valid, store_valid, illegal}));
        if (v.strobes[3]) check_field(names[k], "alu_issue", 128'(exp_alu), 128'(alu_issue));
        if (v.strobes[2]) check_field(names[k], "load_issue", 128'(exp_load), 128'(load_issue));
        if (v.strobes[1]) begin
            check_field(names[k], "store_issue", 128'(exp_store), 128'(store_issue));
        end
    endtask

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // Hang guard
    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        vec_t idle;
        idle        = '0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        cdb_valid   = 1'b0;
        cdb         = '0;
        build_table();
        cycle_limit = rows.size() + 20;

        repeat (5) @(posedge clk_in);
        #1 reset = 1'b0;

        // Results of row i-1 are registered at the edge where row i is driven
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk_in);
            #1;
            if (i > 0) check_row(i - 1);
            if (i < rows.size()) drive_row(rows[i]);
            else drive_row(idle);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
logic/issue_pkg.sv
logic/instr_decoder.sv
logic/operand_table.sv
logic/dispatch_unit.sv
logic/issue_top.sv
tb/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module issue_tb -Mdir obj_dir -o issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
